//--- hw/icache_pkg.sv
`default_nettype none

package icache_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int INDEX_W   = 4;
    localparam int TAG_W     = 12;
    localparam int NUM_LINES = 16;
    // byte offset inside a word, always zero for fetches
    localparam int OFFSET_W  = 2;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } cpu_req_t;

    typedef struct packed {
        logic              ready;
        logic [DATA_W-1:0] data;
    } cpu_rsp_t;

    // addr is word aligned
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic              ready;
        logic [DATA_W-1:0] data;
    } mem_rsp_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } icache_line_t;

endpackage

`default_nettype wire

//--- hw/icache_csr_pkg.sv
`default_nettype none

package icache_csr_pkg;

    typedef enum logic [1:0] {
        CSR_CTRL   = 2'd0,
        CSR_HITS   = 2'd1,
        CSR_MISSES = 2'd2
    } csr_reg_e;

    // bit positions in CSR_CTRL
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_INVAL_BIT  = 1;

    typedef struct packed {
        logic enable;
        logic invalidate;
    } cache_cfg_t;

    typedef struct packed {
        logic hit;
        logic miss;
    } cache_event_t;

endpackage

`default_nettype wire

//--- hw/icache_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_array (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           invalidate,
    input  logic [icache_pkg::INDEX_W-1:0] lookup_index,
    output icache_pkg::icache_line_t       lookup_line,
    input  logic                           fill_en,
    input  logic [icache_pkg::INDEX_W-1:0] fill_index,
    input  logic [icache_pkg::TAG_W-1:0]   fill_tag,
    input  logic [icache_pkg::DATA_W-1:0]  fill_data
);
    import icache_pkg::*;

    logic [NUM_LINES-1:0] valid_q;
    logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
    logic [DATA_W-1:0]    data_mem [NUM_LINES];

    // invalidate has priority over a fill in the same cycle
    always_ff @(posedge clk)
    begin
        if (rst || invalidate)
        begin
            valid_q <= '0;
        end
        else if (fill_en)
        begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_data;
        end
    end

    // combinational read of the indexed line
    always_comb
    begin
        lookup_line.valid = valid_q[lookup_index];
        lookup_line.tag   = tag_mem[lookup_index];
        lookup_line.data  = data_mem[lookup_index];
    end

endmodule

`default_nettype wire

//--- hw/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  icache_pkg::cpu_req_t             cpu_req,
    output icache_pkg::cpu_rsp_t             cpu_rsp,
    output icache_pkg::mem_req_t             mem_req,
    input  icache_pkg::mem_rsp_t             mem_rsp,
    input  icache_csr_pkg::cache_cfg_t       cfg,
    output icache_csr_pkg::cache_event_t     evt,
    output logic [icache_pkg::INDEX_W-1:0]   lookup_index,
    input  icache_pkg::icache_line_t         lookup_line,
    output logic                             fill_en,
    output logic [icache_pkg::INDEX_W-1:0]   fill_index,
    output logic [icache_pkg::TAG_W-1:0]     fill_tag,
    output logic [icache_pkg::DATA_W-1:0]    fill_data
);
    import icache_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_FILL,
        ST_RESPOND
    } state_e;

    state_e state_q;
    state_e state_d;

    logic [ADDR_W-1:0]  addr_q;
    logic [INDEX_W-1:0] req_index;
    logic [TAG_W-1:0]   req_tag;
    logic               hit;
    logic               accept;
    logic               fill_done;
    // enable as seen at compare, decides whether the fill is kept
    logic               cacheable_q;
    logic [DATA_W-1:0]  rsp_data_q;

    assign req_index = addr_q[OFFSET_W +: INDEX_W];
    assign req_tag   = addr_q[OFFSET_W + INDEX_W +: TAG_W];

    assign accept    = (state_q == ST_IDLE) && cpu_req.valid;
    assign fill_done = (state_q == ST_FILL) && mem_rsp.ready;

    // a disabled cache never hits
    assign hit = cfg.enable && lookup_line.valid && (lookup_line.tag == req_tag);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (cpu_req.valid)
                    state_d = ST_COMPARE;
            end
            ST_COMPARE:
            begin
                state_d = hit ? ST_RESPOND : ST_FILL;
            end
            ST_FILL:
            begin
                // wait out memory back-pressure
                if (mem_rsp.ready)
                    state_d = ST_RESPOND;
            end
            ST_RESPOND:
            begin
                state_d = ST_IDLE;
            end
            default:
            begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q     <= ST_IDLE;
            cacheable_q <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == ST_COMPARE)
                cacheable_q <= cfg.enable;
        end
    end

    // request address and response word
    always_ff @(posedge clk)
    begin
        if (accept)
            addr_q <= cpu_req.addr;
        if ((state_q == ST_COMPARE) && hit)
            rsp_data_q <= lookup_line.data;
        else if (fill_done)
            rsp_data_q <= mem_rsp.data;
    end

    // ready is high for the single cycle spent in ST_RESPOND
    always_comb
    begin
        cpu_rsp.ready = (state_q == ST_RESPOND);
        cpu_rsp.data  = rsp_data_q;
    end

    // addr_q only changes in ST_IDLE, so the request holds while valid
    always_comb
    begin
        mem_req.valid = (state_q == ST_FILL);
        mem_req.addr  = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end

    always_comb
    begin
        evt.hit  = (state_q == ST_COMPARE) && hit;
        evt.miss = (state_q == ST_COMPARE) && cfg.enable && !hit;
    end

    assign lookup_index = req_index;
    assign fill_en      = fill_done && cacheable_q;
    assign fill_index   = req_index;
    assign fill_tag     = req_tag;
    assign fill_data    = mem_rsp.data;

endmodule

`default_nettype wire

//--- hw/icache_csr.sv
`timescale 1ns/1ps
`default_nettype none

module icache_csr (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cfg_wr,
    input  icache_csr_pkg::csr_reg_e           cfg_addr,
    input  logic [icache_pkg::DATA_W-1:0]      cfg_wdata,
    output logic [icache_pkg::DATA_W-1:0]      cfg_rdata,
    input  icache_csr_pkg::cache_event_t       evt,
    output icache_csr_pkg::cache_cfg_t         cfg
);
    import icache_pkg::*;
    import icache_csr_pkg::*;

    logic              enable_q;
    logic              inval_q;
    logic [DATA_W-1:0] hits_q;
    logic [DATA_W-1:0] misses_q;
    logic              wr_ctrl;
    logic              wr_hits;
    logic              wr_misses;

    assign wr_ctrl   = cfg_wr && (cfg_addr == CSR_CTRL);
    assign wr_hits   = cfg_wr && (cfg_addr == CSR_HITS);
    assign wr_misses = cfg_wr && (cfg_addr == CSR_MISSES);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            enable_q <= 1'b1;
            inval_q  <= 1'b0;
        end
        else
        begin
            if (wr_ctrl)
                enable_q <= cfg_wdata[CTRL_ENABLE_BIT];
            // one-cycle pulse, never stored
            inval_q <= wr_ctrl && cfg_wdata[CTRL_INVAL_BIT];
        end
    end

    // counters wrap; a write clears, and wins over an event
    always_ff @(posedge clk)
    begin
        if (rst || wr_hits)
            hits_q <= '0;
        else if (evt.hit)
            hits_q <= hits_q + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst || wr_misses)
            misses_q <= '0;
        else if (evt.miss)
            misses_q <= misses_q + 1'b1;
    end

    always_comb
    begin
        cfg_rdata = '0;
        case (cfg_addr)
            CSR_CTRL:   cfg_rdata[CTRL_ENABLE_BIT] = enable_q;
            CSR_HITS:   cfg_rdata = hits_q;
            CSR_MISSES: cfg_rdata = misses_q;
            default:    cfg_rdata = '0;
        endcase
    end

    always_comb
    begin
        cfg.enable     = enable_q;
        cfg.invalidate = inval_q;
    end

endmodule

`default_nettype wire

//--- hw/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  icache_pkg::cpu_req_t          cpu_req,
    output icache_pkg::cpu_rsp_t          cpu_rsp,
    output icache_pkg::mem_req_t          mem_req,
    input  icache_pkg::mem_rsp_t          mem_rsp,
    input  logic                          cfg_wr,
    input  icache_csr_pkg::csr_reg_e      cfg_addr,
    input  logic [icache_pkg::DATA_W-1:0] cfg_wdata,
    output logic [icache_pkg::DATA_W-1:0] cfg_rdata
);
    import icache_pkg::*;
    import icache_csr_pkg::*;

    cache_cfg_t         cfg;
    cache_event_t       evt;
    logic [INDEX_W-1:0] lookup_index;
    icache_line_t       lookup_line;
    logic               fill_en;
    logic [INDEX_W-1:0] fill_index;
    logic [TAG_W-1:0]   fill_tag;
    logic [DATA_W-1:0]  fill_data;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .cpu_rsp      (cpu_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .cfg          (cfg),
        .evt          (evt),
        .lookup_index (lookup_index),
        .lookup_line  (lookup_line),
        .fill_en      (fill_en),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_data    (fill_data)
    );

    // invalidate bypasses the controller
    icache_array u_array (
        .clk          (clk),
        .rst          (rst),
        .invalidate   (cfg.invalidate),
        .lookup_index (lookup_index),
        .lookup_line  (lookup_line),
        .fill_en      (fill_en),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_data    (fill_data)
    );

    icache_csr u_csr (
        .clk       (clk),
        .rst       (rst),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .evt       (evt),
        .cfg       (cfg)
    );

endmodule

`default_nettype wire

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD = 20;

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset held over two rising edges
    initial
    begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb/tb_icache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache_checker (
    input logic                          clk,
    input logic                          rst,
    input icache_pkg::cpu_req_t          cpu_req,
    input icache_pkg::cpu_rsp_t          cpu_rsp,
    input icache_pkg::mem_req_t          mem_req,
    input icache_pkg::mem_rsp_t          mem_rsp,
    input logic                          cfg_wr,
    input icache_csr_pkg::csr_reg_e      cfg_addr,
    input logic [icache_pkg::DATA_W-1:0] cfg_wdata,
    input logic [icache_pkg::DATA_W-1:0] cfg_rdata
);
    import icache_pkg::*;
    import icache_csr_pkg::*;

    string                test_name = "reset";
    int                   error_count = 0;
    logic [NUM_LINES-1:0] valid_m;
    logic [TAG_W-1:0]     tag_m [NUM_LINES];
    logic                 enable_m;
    logic                 fill_m;
    logic                 hit_m;
    logic                 busy;
    logic                 mem_seen;
    logic [DATA_W-1:0]    hits_m;
    logic [DATA_W-1:0]    misses_m;
    logic [ADDR_W-1:0]    req_addr;
    int                   lat;
    int                   beats;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
        error_count++;
    endtask

    task automatic fault(input string what);
        $display("ERROR in %s: %s", test_name, what);
        error_count++;
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            valid_m  = '0;
            enable_m = 1'b1;
            hits_m   = '0;
            misses_m = '0;
            busy     = 1'b0;
        end
        else
        begin
            // register reads are only compared between fetches
            if (!busy && !cfg_wr)
            begin
                if (cfg_addr == CSR_HITS && cfg_rdata !== hits_m)
                    mismatch("hit counter", hits_m, cfg_rdata);
                if (cfg_addr == CSR_MISSES && cfg_rdata !== misses_m)
                    mismatch("miss counter", misses_m, cfg_rdata);
                if (cfg_addr == CSR_CTRL && cfg_rdata !== {31'd0, enable_m})
                    mismatch("control register", {31'd0, enable_m}, cfg_rdata);
            end
            if (cfg_wr && cfg_addr == CSR_CTRL)
            begin
                enable_m = cfg_wdata[0];
                if (cfg_wdata[1])
                    valid_m = '0;
            end
            if (cfg_wr && cfg_addr == CSR_HITS)
                hits_m = '0;
            if (cfg_wr && cfg_addr == CSR_MISSES)
                misses_m = '0;

            if (!busy)
            begin
                if (mem_req.valid || cpu_rsp.ready)
                    fault("cache output active with no fetch pending");
                if (cpu_req.valid)
                begin
                    busy     = 1'b1;
                    req_addr = cpu_req.addr;
                    fill_m   = enable_m;
                    hit_m    = enable_m && valid_m[req_addr[5:2]]
                               && (tag_m[req_addr[5:2]] == req_addr[17:6]);
                    if (enable_m && hit_m)
                        hits_m = hits_m + 32'd1;
                    else if (enable_m)
                        misses_m = misses_m + 32'd1;
                    lat      = 0;
                    beats    = 0;
                    mem_seen = 1'b0;
                end
            end
            else
            begin
                lat++;
                if (mem_req.valid)
                begin
                    mem_seen = 1'b1;
                    if (mem_req.addr !== {req_addr[31:2], 2'b00})
                        mismatch("memory address", {req_addr[31:2], 2'b00}, mem_req.addr);
                    if (mem_rsp.ready)
                        beats++;
                end
                if (cpu_rsp.ready)
                begin
                    if (cpu_rsp.data !== xorshift32({2'b00, req_addr[31:2]}))
                        mismatch("fetch data", xorshift32({2'b00, req_addr[31:2]}),
                                 cpu_rsp.data);
                    if (hit_m && mem_seen)
                        fault("memory request raised for a predicted hit");
                    if (hit_m && lat != 2)
                        mismatch("hit latency", 32'd2, lat);
                    if (!hit_m && beats != 1)
                        mismatch("memory transfers per miss", 32'd1, beats);
                    if (!hit_m && fill_m)
                    begin
                        valid_m[req_addr[5:2]] = 1'b1;
                        tag_m[req_addr[5:2]]   = req_addr[17:6];
                    end
                    busy = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_icache_assert.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache_assert (
    input logic                 clk,
    input logic                 rst,
    input icache_pkg::cpu_rsp_t cpu_rsp,
    input icache_pkg::mem_req_t mem_req
);
    int fail_count = 0;

    // address held for as long as the request is up
    mem_addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid |=> (!mem_req.valid || $stable(mem_req.addr)))
    else
    begin
        $error("memory request address changed while valid was high");
        fail_count++;
    end

    rsp_single_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp.ready |=> !cpu_rsp.ready)
    else
    begin
        $error("cpu response ready high for two cycles in a row");
        fail_count++;
    end

    outputs_low_after_reset: assert property (@(posedge clk)
        rst |=> (!cpu_rsp.ready && !mem_req.valid))
    else
    begin
        $error("cpu ready or memory valid high after reset");
        fail_count++;
    end

endmodule

bind icache_ctrl tb_icache_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .cpu_rsp (cpu_rsp),
    .mem_req (mem_req)
);

`default_nettype wire

//--- tb/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
    import icache_pkg::*;
    import icache_csr_pkg::*;

    localparam logic [31:0] SEED     = 32'h35523110;
    localparam int          MAX_WAIT = 200;
    // tag outside the random pool and unused before the bypass test
    localparam logic [31:0] ADDR_NEW = {14'd0, 12'h777, 4'hc, 2'b00};

    logic              clk;
    logic              rst;
    cpu_req_t          cpu_req;
    cpu_rsp_t          cpu_rsp;
    mem_req_t          mem_req;
    mem_rsp_t          mem_rsp;
    logic              cfg_wr;
    csr_reg_e          cfg_addr;
    logic [DATA_W-1:0] cfg_wdata;
    logic [DATA_W-1:0] cfg_rdata;
    logic [31:0]       stim_rng;
    logic [31:0]       mem_rng;
    logic              hung;
    int                tests_run;
    int                tests_failed;
    int                errors_before;
    int                assert_fails;

    tb_clkgen u_clkgen (
        .clk (clk),
        .rst (rst)
    );

    icache_top u_icache_top (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    tb_icache_checker u_checker (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // three tags shared by all indices
    function automatic logic [31:0] make_addr(input logic [1:0] tag_sel, input logic [3:0] index);
        logic [TAG_W-1:0] tag;
        case (tag_sel)
            2'd0:    tag = 12'h0a5;
            2'd1:    tag = 12'h3c1;
            default: tag = 12'hf07;
        endcase
        return {14'd0, tag, index, 2'b00};
    endfunction

    task automatic fetch(input logic [ADDR_W-1:0] addr);
        int n;
        if (hung)
            return;
        @(posedge clk);
        #2;
        cpu_req.valid = 1'b1;
        cpu_req.addr  = addr;
        n = 0;
        @(negedge clk);
        while (!cpu_rsp.ready && n < MAX_WAIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!cpu_rsp.ready)
        begin
            $display("timeout: no response from the cache for address %h", addr);
            hung = 1'b1;
        end
        @(posedge clk);
        #2;
        cpu_req.valid = 1'b0;
    endtask

    task automatic random_fetches(input int count);
        for (int i = 0; i < count; i++)
        begin
            stim_rng = xorshift32(stim_rng);
            fetch(make_addr(stim_rng[9:8], stim_rng[3:0]));
        end
    endtask

    task automatic csr_write(input csr_reg_e addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        #2;
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #2;
        cfg_wr    = 1'b0;
        cfg_addr  = CSR_CTRL;
        cfg_wdata = '0;
    endtask

    // the checker compares the read data at the edge in between
    task automatic csr_read(input csr_reg_e addr);
        @(posedge clk);
        #2;
        cfg_addr = addr;
        @(posedge clk);
        #2;
        cfg_addr = CSR_CTRL;
    endtask

    task automatic start_test(input string name);
        u_checker.test_name = name;
        errors_before = u_checker.error_count;
    endtask

    task automatic end_test(input string name);
        int n;
        n = u_checker.error_count - errors_before;
        tests_run++;
        if (n != 0 || hung)
            tests_failed++;
        $display("test %s: %s (%0d errors)", name, (n == 0 && !hung) ? "ok" : "failed", n);
    endtask

    // memory answers 0 to 5 cycles after the request
    initial
    begin
        int   wait_left;
        logic pending;
        mem_rsp   = '0;
        mem_rng   = xorshift32(~SEED);
        wait_left = 0;
        pending   = 1'b0;
        forever
        begin
            @(posedge clk);
            #2;
            mem_rsp.ready = 1'b0;
            if (mem_req.valid && !pending)
            begin
                pending   = 1'b1;
                mem_rng   = xorshift32(mem_rng);
                wait_left = mem_rng % 6;
            end
            if (pending && wait_left == 0)
            begin
                mem_rsp.ready = 1'b1;
                mem_rsp.data  = xorshift32({2'b00, mem_req.addr[31:2]});
                pending       = 1'b0;
            end
            else if (pending)
                wait_left--;
        end
    end

    initial
    begin
        int n;
        cpu_req      = '0;
        cfg_wr       = 1'b0;
        cfg_addr     = CSR_CTRL;
        cfg_wdata    = '0;
        stim_rng     = SEED;
        hung         = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        n = 0;
        @(negedge clk);
        while (rst && n < MAX_WAIT)
        begin
            @(negedge clk);
            n++;
        end
        if (rst)
        begin
            $display("timeout: reset was never released");
            hung = 1'b1;
        end

        start_test("data_match");
        random_fetches(40);
        end_test("data_match");

        start_test("hit_no_mem");
        repeat (5) fetch(make_addr(2'd1, 4'd9));
        random_fetches(20);
        end_test("hit_no_mem");

        start_test("conflict_evict");
        csr_write(CSR_HITS, '0);
        csr_write(CSR_MISSES, '0);
        for (int i = 0; i < 8; i++)
            fetch(make_addr(i[0] ? 2'd2 : 2'd0, 4'd5));
        csr_read(CSR_HITS);
        csr_read(CSR_MISSES);
        end_test("conflict_evict");

        start_test("invalidate");
        fetch(make_addr(2'd1, 4'd3));
        fetch(make_addr(2'd1, 4'd3));
        csr_write(CSR_CTRL, 32'h3);
        fetch(make_addr(2'd1, 4'd3));
        csr_read(CSR_MISSES);
        end_test("invalidate");

        start_test("disabled_bypass");
        csr_write(CSR_CTRL, 32'h0);
        random_fetches(10);
        // last access to index 12 before enabling again
        repeat (3) fetch(ADDR_NEW);
        csr_read(CSR_HITS);
        csr_read(CSR_MISSES);
        csr_write(CSR_CTRL, 32'h1);
        fetch(ADDR_NEW);
        end_test("disabled_bypass");

        start_test("backpressure");
        random_fetches(60);
        csr_read(CSR_HITS);
        csr_read(CSR_MISSES);
        end_test("backpressure");

        assert_fails = u_icache_top.u_ctrl.u_assert.fail_count;
        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, u_checker.error_count, assert_fails);
        if (tests_failed == 0 && !hung && u_checker.error_count == 0 && assert_fails == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- icache.f
hw/icache_pkg.sv
hw/icache_csr_pkg.sv
hw/icache_array.sv
hw/icache_ctrl.sv
hw/icache_csr.sv
hw/icache_top.sv
tb/tb_clkgen.sv
tb/tb_icache_checker.sv
tb/tb_icache_assert.sv
tb/tb_icache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_icache -f icache.f -o sim_icache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_icache +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
